// ==== core_pkg.sv ====
package core_pkg;

    // Integer datapath width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Operations of the single-cycle ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // Fetch sequencing
    typedef enum logic [1:0] {
        FETCH_REQ  = 2'd0,
        FETCH_WAIT = 2'd1,
        FETCH_HOLD = 2'd2
    } fetch_state_t;

    // RV32I major opcodes accepted by decode
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // First fetch address
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_ready,
    input  core_pkg::word_t imem_read_data,
    input  logic            decode_stall,
    output logic            imem_read_en,
    output core_pkg::word_t imem_addr,
    output logic            instr_valid,
    output core_pkg::word_t instr
);

    core_pkg::fetch_state_t state;
    core_pkg::word_t        pc;

    assign imem_addr   = pc;
    assign instr_valid = (state == core_pkg::FETCH_HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= core_pkg::FETCH_REQ;
            pc           <= core_pkg::RESET_PC;
            imem_read_en <= 1'b0;
        end else begin
            case (state)
                core_pkg::FETCH_REQ: begin
                    imem_read_en <= 1'b1;
                    state        <= core_pkg::FETCH_WAIT;
                end
                core_pkg::FETCH_WAIT: begin
                    // Request stays up until memory answers
                    if (imem_ready) begin
                        imem_read_en <= 1'b0;
                        state        <= core_pkg::FETCH_HOLD;
                    end
                end
                core_pkg::FETCH_HOLD: begin
                    // Advance once decode takes the word
                    if (!decode_stall) begin
                        pc    <= pc + 32'd4;
                        state <= core_pkg::FETCH_REQ;
                    end
                end
                default: state <= core_pkg::FETCH_REQ;
            endcase
        end
    end

    // Captured word held until decode takes it
    always_ff @(posedge clk) begin
        if (state == core_pkg::FETCH_WAIT && imem_ready) begin
            instr <= imem_read_data;
        end
    end

    // Memory must not answer while a word is still held
    assert property (@(posedge clk) disable iff (reset)
        state == core_pkg::FETCH_HOLD |-> !imem_ready);

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage #(
    parameter  int ROB_DEPTH = 8,
    localparam int IDX_W     = $clog2(ROB_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  core_pkg::word_t     instr,
    input  logic                full,
    input  logic                rs1_pending,
    input  logic                rs2_pending,
    input  logic                rs1_bypass,
    input  logic                rs2_bypass,
    input  core_pkg::word_t     rs1_bypass_value,
    input  core_pkg::word_t     rs2_bypass_value,
    input  core_pkg::word_t     rf_rs1_value,
    input  core_pkg::word_t     rf_rs2_value,
    input  logic [IDX_W-1:0]    alloc_idx,
    output logic                decode_stall,
    output logic                alloc,
    output logic                alloc_write,
    output logic                issue_valid,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::reg_addr_t alloc_rd,
    output core_pkg::alu_op_t   issue_op,
    output core_pkg::word_t     issue_a,
    output core_pkg::word_t     issue_b,
    output logic [IDX_W-1:0]    issue_idx
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              is_op;
    logic              is_op_imm;
    logic              is_shift;
    logic              legal;
    logic              take;
    core_pkg::alu_op_t op;
    core_pkg::word_t   imm;
    core_pkg::word_t   operand_a;
    core_pkg::word_t   operand_b;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign alloc_rd  = instr[11:7];
    assign is_op     = (opcode == core_pkg::OPCODE_OP);
    assign is_op_imm = (opcode == core_pkg::OPCODE_OP_IMM);
    assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  op = (is_op && funct7[5]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  op = core_pkg::ALU_SLL;
            3'b010:  op = core_pkg::ALU_SLT;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b101:  op = core_pkg::ALU_SRL;
            3'b110:  op = core_pkg::ALU_OR;
            3'b111:  op = core_pkg::ALU_AND;
            default: op = core_pkg::ALU_ADD;
        endcase
        // SLTU, SRA and odd funct7 patterns are not supported
        legal = 1'b0;
        if (is_op) begin
            legal = (funct3 != 3'b011) &&
                    ((funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000));
        end else if (is_op_imm) begin
            legal = (funct3 != 3'b011) && (!is_shift || funct7 == 7'b0000000);
        end
    end

    // Shifts take shamt, everything else the sign-extended immediate
    assign imm = is_shift ? {27'b0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};

    assign operand_a = rs1_bypass ? rs1_bypass_value : rf_rs1_value;
    assign operand_b = is_op_imm ? imm : (rs2_bypass ? rs2_bypass_value : rf_rs2_value);

    // Wait for a free entry and for in-flight producers of used sources
    assign decode_stall = instr_valid &&
                          (full || ((is_op || is_op_imm) && rs1_pending) || (is_op && rs2_pending));

    assign take        = instr_valid && !decode_stall;
    assign alloc       = take;
    assign alloc_write = legal && (alloc_rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            issue_op  <= op;
            issue_a   <= operand_a;
            issue_b   <= operand_b;
            issue_idx <= alloc_idx;
        end
    end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                commit_valid,
    input  logic                commit_write,
    input  core_pkg::reg_addr_t commit_rd,
    input  core_pkg::word_t     commit_value,
    output core_pkg::word_t     rs1_value,
    output core_pkg::word_t     rs2_value
);

    core_pkg::word_t regs [32];
    logic            wr_en;

    assign wr_en = commit_valid && commit_write && (commit_rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[commit_rd] <= commit_value;
        end
    end

    // The committing value is visible in the same cycle it is written
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1_value = '0;
        end else if (wr_en && commit_rd == rs1) begin
            rs1_value = commit_value;
        end else begin
            rs1_value = regs[rs1];
        end
        if (rs2 == 5'd0) begin
            rs2_value = '0;
        end else if (wr_en && commit_rd == rs2) begin
            rs2_value = commit_value;
        end else begin
            rs2_value = regs[rs2];
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
    parameter  int ROB_DEPTH = 8,
    localparam int IDX_W     = $clog2(ROB_DEPTH)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  core_pkg::alu_op_t issue_op,
    input  core_pkg::word_t   issue_a,
    input  core_pkg::word_t   issue_b,
    input  logic [IDX_W-1:0]  issue_idx,
    output logic              complete,
    output logic [IDX_W-1:0]  complete_idx,
    output core_pkg::word_t   complete_value
);

    core_pkg::word_t result;
    logic            less;

    assign less = $signed(issue_a) < $signed(issue_b);

    always_comb begin
        case (issue_op)
            core_pkg::ALU_ADD: result = issue_a + issue_b;
            core_pkg::ALU_SUB: result = issue_a - issue_b;
            core_pkg::ALU_AND: result = issue_a & issue_b;
            core_pkg::ALU_OR:  result = issue_a | issue_b;
            core_pkg::ALU_XOR: result = issue_a ^ issue_b;
            // Shift amount is the low five bits only
            core_pkg::ALU_SLL: result = issue_a << issue_b[4:0];
            core_pkg::ALU_SRL: result = issue_a >> issue_b[4:0];
            core_pkg::ALU_SLT: result = {{(core_pkg::XLEN-1){1'b0}}, less};
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            complete <= 1'b0;
        end else begin
            complete <= issue_valid;
        end
    end

    // Result travels with its ROB slot
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            complete_idx   <= issue_idx;
            complete_value <= result;
        end
    end

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
    parameter  int ROB_DEPTH = 8,
    localparam int IDX_W     = $clog2(ROB_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  logic                alloc_write,
    input  core_pkg::reg_addr_t alloc_rd,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                complete,
    input  logic [IDX_W-1:0]    complete_idx,
    input  core_pkg::word_t     complete_value,
    output logic [IDX_W-1:0]    alloc_idx,
    output logic                full,
    output logic                rs1_pending,
    output logic                rs2_pending,
    output logic                rs1_bypass,
    output logic                rs2_bypass,
    output logic                commit_valid,
    output logic                commit_write,
    output core_pkg::word_t     rs1_bypass_value,
    output core_pkg::word_t     rs2_bypass_value,
    output core_pkg::word_t     commit_value,
    output core_pkg::reg_addr_t commit_rd,
    output logic                core_ready
);

    logic [IDX_W-1:0]    head;
    logic [IDX_W-1:0]    tail;
    logic [IDX_W:0]      count;
    logic                commit_fire;
    logic                busy        [ROB_DEPTH];
    logic                done        [ROB_DEPTH];
    logic                entry_write [ROB_DEPTH];
    core_pkg::reg_addr_t entry_rd    [ROB_DEPTH];
    core_pkg::word_t     entry_value [ROB_DEPTH];

    assign alloc_idx   = tail;
    assign full        = (count == (IDX_W+1)'(ROB_DEPTH));
    assign commit_fire = busy[head] && done[head];
    assign core_ready  = (count == '0) && !commit_valid;

    // Walk oldest to youngest so the youngest writer wins
    function automatic void lookup(
        input  core_pkg::reg_addr_t rs,
        output logic                pending,
        output logic                bypass,
        output core_pkg::word_t     value
    );
        logic [IDX_W-1:0] idx;
        logic             hit;
        logic             hit_done;
        hit      = 1'b0;
        hit_done = 1'b0;
        value    = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            idx = head + IDX_W'(i);
            if (busy[idx] && entry_write[idx] && entry_rd[idx] == rs) begin
                hit      = 1'b1;
                hit_done = done[idx];
                value    = entry_value[idx];
            end
        end
        pending = hit && !hit_done;
        bypass  = hit && hit_done;
    endfunction

    always_comb begin
        lookup(rs1, rs1_pending, rs1_bypass, rs1_bypass_value);
        lookup(rs2, rs2_pending, rs2_bypass, rs2_bypass_value);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
                done[i] <= 1'b0;
            end
        end else begin
            commit_valid <= commit_fire;
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (complete) begin
                done[complete_idx] <= 1'b1;
            end
            if (commit_fire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + (IDX_W+1)'(alloc) - (IDX_W+1)'(commit_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_rd[tail]    <= alloc_rd;
            entry_write[tail] <= alloc_write;
        end
        if (complete) begin
            entry_value[complete_idx] <= complete_value;
        end
        if (commit_fire) begin
            commit_write <= entry_write[head];
            commit_rd    <= entry_rd[head];
            commit_value <= entry_value[head];
        end
    end

    // Execute only finishes slots that decode handed out
    assert property (@(posedge clk) disable iff (reset) complete |-> busy[complete_idx]);

    // Decode must stall on a full buffer
    assert property (@(posedge clk) disable iff (reset) alloc |-> !full);

    // A commit pulse always drains a real entry
    assert property (@(posedge clk) disable iff (reset) commit_valid |-> $past(count != '0));

endmodule

// ==== core.sv ====
`timescale 1ns/1ps

module core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_ready,
    input  core_pkg::word_t     imem_read_data,
    output logic                imem_read_en,
    output core_pkg::word_t     imem_addr,
    output logic                commit_valid,
    output logic                commit_write,
    output core_pkg::reg_addr_t commit_rd,
    output core_pkg::word_t     commit_value,
    output logic                core_ready
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // Fetch to decode
    logic                instr_valid;
    core_pkg::word_t     instr;
    logic                decode_stall;

    // Decode and ROB
    logic                alloc;
    logic                alloc_write;
    core_pkg::reg_addr_t alloc_rd;
    logic [IDX_W-1:0]    alloc_idx;
    logic                full;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    logic                rs1_pending;
    logic                rs2_pending;
    logic                rs1_bypass;
    logic                rs2_bypass;
    core_pkg::word_t     rs1_bypass_value;
    core_pkg::word_t     rs2_bypass_value;
    core_pkg::word_t     rf_rs1_value;
    core_pkg::word_t     rf_rs2_value;

    // Issue and completion
    logic                issue_valid;
    core_pkg::alu_op_t   issue_op;
    core_pkg::word_t     issue_a;
    core_pkg::word_t     issue_b;
    logic [IDX_W-1:0]    issue_idx;
    logic                complete;
    logic [IDX_W-1:0]    complete_idx;
    core_pkg::word_t     complete_value;

    fetch_unit fetch (
        .clk(clk), .reset(reset), .imem_ready(imem_ready), .imem_read_data(imem_read_data),
        .decode_stall(decode_stall), .imem_read_en(imem_read_en), .imem_addr(imem_addr),
        .instr_valid(instr_valid), .instr(instr)
    );

    decode_stage #(.ROB_DEPTH(ROB_DEPTH)) decode (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .full(full),
        .rs1_pending(rs1_pending), .rs2_pending(rs2_pending),
        .rs1_bypass(rs1_bypass), .rs2_bypass(rs2_bypass),
        .rs1_bypass_value(rs1_bypass_value), .rs2_bypass_value(rs2_bypass_value),
        .rf_rs1_value(rf_rs1_value), .rf_rs2_value(rf_rs2_value), .alloc_idx(alloc_idx),
        .decode_stall(decode_stall), .alloc(alloc), .alloc_write(alloc_write),
        .issue_valid(issue_valid), .rs1(rs1), .rs2(rs2), .alloc_rd(alloc_rd),
        .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b), .issue_idx(issue_idx)
    );

    register_file regfile (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .commit_valid(commit_valid),
        .commit_write(commit_write), .commit_rd(commit_rd), .commit_value(commit_value),
        .rs1_value(rf_rs1_value), .rs2_value(rf_rs2_value)
    );

    execute_stage #(.ROB_DEPTH(ROB_DEPTH)) execute (
        .clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_idx(issue_idx), .complete(complete),
        .complete_idx(complete_idx), .complete_value(complete_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob (
        .clk(clk), .reset(reset), .alloc(alloc), .alloc_write(alloc_write),
        .alloc_rd(alloc_rd), .rs1(rs1), .rs2(rs2), .complete(complete),
        .complete_idx(complete_idx), .complete_value(complete_value), .alloc_idx(alloc_idx),
        .full(full), .rs1_pending(rs1_pending), .rs2_pending(rs2_pending),
        .rs1_bypass(rs1_bypass), .rs2_bypass(rs2_bypass), .commit_valid(commit_valid),
        .commit_write(commit_write), .rs1_bypass_value(rs1_bypass_value),
        .rs2_bypass_value(rs2_bypass_value), .commit_value(commit_value),
        .commit_rd(commit_rd), .core_ready(core_ready)
    );

endmodule

// ==== core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int PROG_LEN    = 48;
    localparam int PAD_LEN     = 4;
    localparam int FETCH_LIMIT = PROG_LEN + PAD_LEN;
    localparam int WATCHDOG_NS = (PROG_LEN + 16) * 7 * 4;
    localparam core_pkg::word_t NOP = 32'h0000_0013;

    logic                clk;
    logic                reset;
    logic                imem_ready;
    core_pkg::word_t     imem_read_data;
    logic                imem_read_en;
    core_pkg::word_t     imem_addr;
    logic                commit_valid;
    logic                commit_write;
    core_pkg::reg_addr_t commit_rd;
    core_pkg::word_t     commit_value;
    logic                core_ready;

    int              seed = 32'hebad;
    int              errors = 0;
    int              checks = 0;
    int              fetched = 0;
    int              commit_count = 0;
    core_pkg::word_t prog [PROG_LEN];
    core_pkg::word_t model_regs [32];

    core #(.ROB_DEPTH(8)) DUT (
        .clk(clk), .reset(reset), .imem_ready(imem_ready), .imem_read_data(imem_read_data),
        .imem_read_en(imem_read_en), .imem_addr(imem_addr), .commit_valid(commit_valid),
        .commit_write(commit_write), .commit_rd(commit_rd), .commit_value(commit_value),
        .core_ready(core_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_word(input string name, input core_pkg::word_t exp,
                              input core_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_addr_t exp,
                             input core_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected x%0d got x%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    function automatic core_pkg::word_t rtype(input logic [6:0] funct7,
                                              input core_pkg::reg_addr_t rs2,
                                              input core_pkg::reg_addr_t rs1,
                                              input logic [2:0] funct3,
                                              input core_pkg::reg_addr_t rd);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::OPCODE_OP};
    endfunction

    function automatic core_pkg::word_t itype(input logic [11:0] imm,
                                              input core_pkg::reg_addr_t rs1,
                                              input logic [2:0] funct3,
                                              input core_pkg::reg_addr_t rd);
        return {imm, rs1, funct3, rd, core_pkg::OPCODE_OP_IMM};
    endfunction

    // Word at program slot k or ADDI x0 past the end
    function automatic core_pkg::word_t instr_at(input int k);
        return (k < PROG_LEN) ? prog[k] : NOP;
    endfunction

    function automatic logic writes_reg(input core_pkg::word_t ins);
        return (ins[6:0] == core_pkg::OPCODE_OP || ins[6:0] == core_pkg::OPCODE_OP_IMM) &&
               (ins[11:7] != 5'd0);
    endfunction

    // ISA result against the architectural model registers
    function automatic core_pkg::word_t alu_ref(input core_pkg::word_t ins);
        core_pkg::word_t a;
        core_pkg::word_t b;
        logic            is_reg;
        is_reg = (ins[6:0] == core_pkg::OPCODE_OP);
        a = model_regs[ins[19:15]];
        b = is_reg ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        case (ins[14:12])
            3'b000:  return (is_reg && ins[30]) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] imm_r;
        logic [2:0]  f3;
        // Chain of five through x1..x5 followed by an x0 write, an odd opcode and an x0 read
        prog[0] = itype(12'hffb, 5'd0, 3'b000, 5'd1);
        prog[1] = itype(12'd12, 5'd1, 3'b000, 5'd2);
        prog[2] = rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd3);
        prog[3] = rtype(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
        prog[4] = itype(12'd28, 5'd4, 3'b101, 5'd5);
        prog[5] = rtype(7'h00, 5'd1, 5'd5, 3'b000, 5'd0);
        prog[6] = {12'h000, 5'd5, 3'b000, 5'd7, 7'b1011011};
        prog[7] = rtype(7'h00, 5'd5, 5'd0, 3'b100, 5'd6);
        for (int i = 8; i < PROG_LEN; i++) begin
            r     = $random(seed);
            imm_r = $random(seed);
            f3    = (r[11:9] == 3'b011) ? 3'b000 : r[11:9];
            // Small register window keeps dependencies frequent
            if (r[15:12] == 4'hf) begin
                prog[i] = {imm_r[11:0], 2'b00, r[5:3], f3, 2'b00, r[2:0], 7'b1011011};
            end else if (r[15:12] < 4'd7) begin
                prog[i] = rtype((f3 == 3'b000 && r[16]) ? 7'h20 : 7'h00, {2'b00, r[8:6]},
                                {2'b00, r[5:3]}, f3, {2'b00, r[2:0]});
            end else if (f3 == 3'b001 || f3 == 3'b101) begin
                prog[i] = itype({7'b0, imm_r[4:0]}, {2'b00, r[5:3]}, f3, {2'b00, r[2:0]});
            end else begin
                prog[i] = itype(imm_r[11:0], {2'b00, r[5:3]}, f3, {2'b00, r[2:0]});
            end
        end
    endtask

    // Instruction memory answering after 1 to 4 cycles
    initial begin : memory_model
        logic [31:0] r;
        int          wait_left;
        bit          in_flight;
        imem_ready     = 1'b0;
        imem_read_data = '0;
        in_flight      = 1'b0;
        wait_left      = 0;
        forever begin
            @(posedge clk);
            #1;
            if (imem_ready) begin
                imem_ready = 1'b0;
                check_bit("imem_read_en", 1'b0, imem_read_en);
            end else if (in_flight) begin
                if (imem_read_en !== 1'b1) begin
                    errors++;
                    $display("imem_read_en dropped at %0t before imem_ready came", $time);
                end
                wait_left--;
                if (wait_left == 0) begin
                    imem_ready     = 1'b1;
                    imem_read_data = instr_at(fetched);
                    fetched++;
                    in_flight      = 1'b0;
                end
            end else if (!reset && imem_read_en === 1'b1 && fetched < FETCH_LIMIT) begin
                check_word("imem_addr", core_pkg::RESET_PC + 32'(4 * fetched), imem_addr);
                r         = $random(seed);
                wait_left = 1 + r[1:0];
                in_flight = 1'b1;
            end
        end
    end

    initial begin : commit_compare
        core_pkg::word_t ins;
        core_pkg::word_t expected;
        logic            expect_write;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && commit_valid === 1'b1) begin
                if (commit_count >= fetched) begin
                    errors++;
                    $display("Commit at %0t has no fetched instruction behind it", $time);
                end else begin
                    ins          = instr_at(commit_count);
                    expect_write = writes_reg(ins);
                    expected     = alu_ref(ins);
                    check_bit("commit_write", expect_write, commit_write);
                    check_reg("commit_rd", ins[11:7], commit_rd);
                    if (expect_write) begin
                        check_word("commit_value", expected, commit_value);
                        model_regs[ins[11:7]] = expected;
                    end
                end
                commit_count++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t with %0d of %0d instructions committed",
                 $time, commit_count, FETCH_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int drain;
        reset = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (10) begin
            @(posedge clk);
            #1;
            check_bit("imem_read_en", 1'b0, imem_read_en);
            check_bit("commit_valid", 1'b0, commit_valid);
            check_bit("core_ready", 1'b1, core_ready);
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_bit("imem_read_en", 1'b1, imem_read_en);
        wait (commit_count == FETCH_LIMIT);
        drain = 0;
        while (core_ready !== 1'b1 && drain < 20) begin
            @(posedge clk);
            #1;
            drain++;
        end
        check_bit("core_ready", 1'b1, core_ready);
        // No stray commits once the fetch supply ends
        repeat (8) @(posedge clk);
        #1;
        if (commit_count != fetched) begin
            errors++;
            $display("Committed %0d instructions but fetched %0d", commit_count, fetched);
        end
        $display("Checks: %0d, errors: %0d, commits: %0d, fetched: %0d",
                 checks, errors, commit_count, fetched);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
core_pkg.sv
fetch_unit.sv
decode_stage.sv
register_file.sv
execute_stage.sv
reorder_buffer.sv
core.sv
core_tb.sv

// ==== Bender.yml ====
package:
  name: inorder_core

sources:
  - core_pkg.sv
  - fetch_unit.sv
  - decode_stage.sv
  - register_file.sv
  - execute_stage.sv
  - reorder_buffer.sv
  - core.sv
  - target: test
    files:
      - core_tb.sv
